/* run_sim.sh */
#!/bin/sh
# Builds and runs the monopix periphery testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f --top-module monopixTb -o monopixSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/monopixSim > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -q "RESULT: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "RESULT: PASS" sim.log; then
    echo "No result line found in sim.log"
    exit 1
fi
exit 0

/* sim.f */
src/monoDataPkg.sv
src/monoCfgPkg.sv
src/monoCfgReg.sv
src/dacDecode.sv
src/bunchCrossing.sv
src/hitOrMonitor.sv
src/monopixTop.sv
testbench/monopixTb.sv

/* src/bunchCrossing.sv */
`timescale 1ns/10ps

module bunchCrossing
    import monoDataPkg::*, monoCfgPkg::*;
#(
    parameter int BcidWidth = 6
)(
    input  logic                 ClkBx,
    input  logic                 reset_ff,
    input  logic                 ResetBcid,
    input  logic                 Pulse,
    input  monoConf_t            Conf,
    output logic [BcidWidth-1:0] Bcid,
    output colMask_t             InjCol,
    output logic                 InjMonL,
    output logic                 InjMonR
);

    logic [BcidWidth-1:0] bcidBin;

    always_ff @(posedge ClkBx) begin
        if (reset_ff || ResetBcid)
            bcidBin <= '0;
        else
            bcidBin <= bcidBin + 1'b1;   // Wraps at full count
    end

    // Gray code, one bit flips per crossing for the matrix latches
    assign Bcid = bcidBin ^ (bcidBin >> 1);

    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            InjCol  <= '0;
            InjMonL <= 1'b0;
            InjMonR <= 1'b0;
        end else begin
            InjCol  <= {ColCount{Pulse}} & Conf.colPulseSel;
            InjMonL <= Pulse & Conf.injMonL;
            InjMonR <= Pulse & Conf.injMonR;
        end
    end

    injInSelection: assert property (@(posedge ClkBx) disable iff (reset_ff)
        (InjCol & ~$past(Conf.colPulseSel)) == '0)
        else $error("Injection on a column outside colPulseSel");

endmodule

/* src/dacDecode.sv */
`timescale 1ns/10ps

module dacDecode
    import monoDataPkg::*, monoCfgPkg::*;
(
    input  logic      ClkBx,
    input  logic      reset_ff,
    input  monoConf_t Conf,
    output dacLevel_t DacLevel,
    output logic      DacValid
);

    logic [DacLines-1:0] hotWord;
    logic [DacLines-1:0] thermoWord;
    logic [DacLines-1:0] runStarts;
    dacLevel_t           hotIdx;
    dacLevel_t           nextLevel;
    logic                nextValid;

    assign hotWord    = Conf.dacSet.oneHot;
    assign thermoWord = Conf.dacSet.thermo;

    // A one with a zero below it opens a run
    assign runStarts = thermoWord & ~{thermoWord[DacLines-2:0], 1'b0};

    // OR of the indices of all set lines
    // Exact only for a clean one-hot word
    always_comb begin
        hotIdx = '0;
        for (int i = 0; i < DacLines; i++) begin
            if (hotWord[i])
                hotIdx = hotIdx | dacLevel_t'(i);
        end
    end

    always_comb begin
        if (Conf.dacKind) begin
            nextValid = $onehot0(runStarts);                 // Zero or one run
            nextLevel = dacLevel_t'($countones(thermoWord));
        end else begin
            nextValid = $onehot(hotWord);
            nextLevel = hotIdx;
        end
    end

    always_ff @(posedge ClkBx) begin
        if (reset_ff) begin
            DacLevel <= '0;
            DacValid <= 1'b0;
        end else begin
            DacLevel <= nextValid ? nextLevel : '0;   // Bad word reads as zero
            DacValid <= nextValid;
        end
    end

    levelInRange: assert property (@(posedge ClkBx) disable iff (reset_ff)
        DacLevel <= dacLevel_t'(DacLines))
        else $error("DAC level %0d above the %0d lines", DacLevel, DacLines);

endmodule

/* src/hitOrMonitor.sv */
`timescale 1ns/10ps

module hitOrMonitor
    import monoDataPkg::*, monoCfgPkg::*;
(
    input  logic        ClkBx,
    input  logic        reset_ff,
    input  digMon_t     DigMon,
    input  monoConf_t   Conf,
    output flavorMask_t HitOr
);

    flavorMask_t hitAny;   // Fast OR before the enable

    // Same column select for every flavor
    always_comb begin
        for (int f = 0; f < NumFlavors; f++)
            hitAny[f] = |(DigMon[f] & Conf.digMonSel);
    end

    always_ff @(posedge ClkBx) begin
        if (reset_ff)
            HitOr <= '0;
        else
            HitOr <= hitAny & Conf.enHitOrOut;
    end

endmodule

/* src/monoCfgPkg.sv */
package monoCfgPkg;

    import monoDataPkg::*;

    // Shift order follows the field order, MSB leaves first on SoConf
    typedef struct packed {
        flavorMask_t enHitOrOut;    // Hit-OR output enable, active high
        colMask_t    digMonSel;     // Columns seen by the hit-OR
        colMask_t    colPulseSel;   // Columns that take the injection pulse
        logic        injMonL;       // Left monitor pixel injection
        logic        injMonR;       // Right monitor pixel injection
        logic        dacKind;       // 0 one-hot, 1 thermometer
        dacSetting_u dacSet;
    } monoConf_t;

    localparam int ConfBits = $bits(monoConf_t);

    // Power-up state, everything quiet
    // DAC parked on voltage line 9
    localparam monoConf_t DefaultConf = '{
        enHitOrOut:  '0,
        digMonSel:   '0,
        colPulseSel: '0,
        injMonL:     1'b0,
        injMonR:     1'b0,
        dacKind:     1'b0,
        dacSet:      dacSetting_u'(16'h0200)
    };

endpackage

/* src/monoCfgReg.sv */
`timescale 1ns/10ps

module monoCfgReg
    import monoCfgPkg::*;
(
    input  logic      ClkBx,
    input  logic      reset_ff,
    input  logic      ShiftEn,
    input  logic      SiConf,
    input  logic      LdConf,
    input  logic      DefConf,
    output logic      SoConf,
    output monoConf_t Conf
);

    logic [ConfBits-1:0] shadowReg;   // Serial side, not seen by the chip

    always_ff @(posedge ClkBx) begin
        if (reset_ff || DefConf) begin
            shadowReg <= DefaultConf;
            Conf      <= DefaultConf;
        end else if (LdConf) begin
            Conf <= monoConf_t'(shadowReg);   // Shadow keeps its content
        end else if (ShiftEn) begin
            shadowReg <= {shadowReg[ConfBits-2:0], SiConf};   // In at LSB
        end
    end

    // Read-back of the shadow, first bit in comes out first
    assign SoConf = shadowReg[ConfBits-1];

    defAfterReset: assert property (@(posedge ClkBx)
        reset_ff |=> Conf == DefaultConf)
        else $error("Configuration not at default one cycle after reset");

endmodule

/* src/monoDataPkg.sv */
package monoDataPkg;

    // Matrix geometry kept in the periphery
    localparam int ColCount   = 8;
    localparam int NumFlavors = 4;      // PMOS_NOSF, PMOS, COMP, HV

    localparam int DacLines = 16;

    typedef logic [NumFlavors-1:0] flavorMask_t;   // One bit per flavor
    typedef logic [ColCount-1:0]   colMask_t;      // One bit per column

    // Digital monitor lines, one row of columns per flavor
    typedef logic [NumFlavors-1:0][ColCount-1:0] digMon_t;

    // One DAC word, read as voltage line or as current level
    typedef union packed {
        logic [DacLines-1:0] oneHot;   // Single set line
        logic [DacLines-1:0] thermo;   // Contiguous run of ones
    } dacSetting_u;

    // Must reach DacLines itself for a full thermometer word
    typedef logic [$clog2(DacLines+1)-1:0] dacLevel_t;

endpackage

/* src/monopixTop.sv */
`timescale 1ns/10ps

module monopixTop
    import monoDataPkg::*, monoCfgPkg::*;
#(
    parameter int BcidWidth = 6
)(
    input  logic                 ClkBx,
    input  logic                 reset_ff,
    input  logic                 ShiftEn,      // Serial config clock as a strobe
    input  logic                 SiConf,
    input  logic                 LdConf,
    input  logic                 DefConf,
    input  logic                 ResetBcid,
    input  logic                 Pulse,
    input  digMon_t              DigMon,       // From the matrix
    output logic                 SoConf,
    output logic [BcidWidth-1:0] Bcid,
    output colMask_t             InjCol,
    output logic                 InjMonL,
    output logic                 InjMonR,
    output flavorMask_t          HitOr,
    output dacLevel_t            DacLevel,
    output logic                 DacValid
);

    monoConf_t conf;   // Active configuration for all stages

    monoCfgReg uCfgReg (
        .ClkBx    (ClkBx),
        .reset_ff (reset_ff),
        .ShiftEn  (ShiftEn),
        .SiConf   (SiConf),
        .LdConf   (LdConf),
        .DefConf  (DefConf),
        .SoConf   (SoConf),
        .Conf     (conf)
    );

    dacDecode uDacDecode (
        .ClkBx    (ClkBx),
        .reset_ff (reset_ff),
        .Conf     (conf),
        .DacLevel (DacLevel),
        .DacValid (DacValid)
    );

    bunchCrossing #(
        .BcidWidth (BcidWidth)
    ) uBunchCrossing (
        .ClkBx     (ClkBx),
        .reset_ff  (reset_ff),
        .ResetBcid (ResetBcid),
        .Pulse     (Pulse),
        .Conf      (conf),
        .Bcid      (Bcid),
        .InjCol    (InjCol),
        .InjMonL   (InjMonL),
        .InjMonR   (InjMonR)
    );

    hitOrMonitor uHitOrMonitor (
        .ClkBx    (ClkBx),
        .reset_ff (reset_ff),
        .DigMon   (DigMon),
        .Conf     (conf),
        .HitOr    (HitOr)
    );

endmodule

/* testbench/monopixTb.sv */
`timescale 1ns/10ps

module monopixTb
    import monoDataPkg::*, monoCfgPkg::*;
();

    localparam int BcidWidth   = 6;
    localparam int MaxSteps    = 64;
    localparam int ResetCycles = 10;

    logic ClkBx, reset_ff, ShiftEn, SiConf, LdConf, DefConf, ResetBcid, Pulse;
    digMon_t              DigMon;
    logic                 SoConf;
    logic [BcidWidth-1:0] Bcid;
    colMask_t             InjCol;
    logic                 InjMonL, InjMonR;
    flavorMask_t          HitOr;
    dacLevel_t            DacLevel;
    logic                 DacValid;

    // One entry per trace line
    logic [127:0]        stepName [MaxSteps];
    logic [7:0]          stepOp   [MaxSteps];   // c cycle, s shift, l load, d default, b bcid
    logic                pulseV   [MaxSteps];
    logic                rstBcidV [MaxSteps];
    digMon_t             digMonV  [MaxSteps];
    logic [ConfBits-1:0] wordV    [MaxSteps];
    logic [4:0]          maskV    [MaxSteps];
    colMask_t            expInjV  [MaxSteps];
    logic [1:0]          expMonV  [MaxSteps];   // L then R
    flavorMask_t         expHitV  [MaxSteps];
    dacLevel_t           expDacV  [MaxSteps];
    logic                expValV  [MaxSteps];
    logic [ConfBits-1:0] expSoV   [MaxSteps];

    int numSteps    = 0;
    int totalCycles = 0;
    int pendIdx     = -1;   // Step whose results show at the next negedge
    int valueErrors = 0;
    int otherErrors = 0;
    int cycleCount  = 0;
    int cycleLimit  = 0;

    monopixTop #(.BcidWidth(BcidWidth)) u_dut (
        .ClkBx(ClkBx), .reset_ff(reset_ff), .ShiftEn(ShiftEn), .SiConf(SiConf),
        .LdConf(LdConf), .DefConf(DefConf), .ResetBcid(ResetBcid), .Pulse(Pulse),
        .DigMon(DigMon), .SoConf(SoConf), .Bcid(Bcid), .InjCol(InjCol),
        .InjMonL(InjMonL), .InjMonR(InjMonR), .HitOr(HitOr),
        .DacLevel(DacLevel), .DacValid(DacValid)
    );

    initial begin
        ClkBx = 1'b0;
        forever #20 ClkBx = ~ClkBx;
    end

    always @(posedge ClkBx) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit) begin
            $display("ERROR: run stopped after %0d cycles without finishing", cycleCount);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    // Reflected binary code, the upper half mirrors the lower half
    function automatic logic [BcidWidth-1:0] grayOf(input int count);
        logic [BcidWidth-1:0] code;
        int                   rest;
        int                   half;
        code = '0;
        rest = count % (1 << BcidWidth);   // Counter wraps at 64
        for (int b = BcidWidth - 1; b >= 0; b--) begin
            half = 1 << b;
            if (rest >= half) begin
                code[b] = 1'b1;
                rest    = 2 * half - 1 - rest;   // Mirror into the lower half
            end
        end
        return code;
    endfunction

    task automatic checkBcid(input logic [127:0] name, input logic [BcidWidth-1:0] exp,
                             input logic [BcidWidth-1:0] act);
        if (act !== exp) begin
            $display("FAIL %0s Bcid: expected %h, actual %h", name, exp, act);
            valueErrors++;
        end
    endtask

    task automatic checkInj(input logic [127:0] name, input colMask_t exp, input colMask_t act);
        if (act !== exp) begin
            $display("FAIL %0s InjCol: expected %h, actual %h", name, exp, act);
            valueErrors++;
        end
    endtask

    task automatic checkMon(input logic [127:0] name, input logic [1:0] exp,
                            input logic [1:0] act);
        if (act !== exp) begin
            $display("FAIL %0s InjMon: expected %b, actual %b", name, exp, act);
            valueErrors++;
        end
    endtask

    task automatic checkHitOr(input logic [127:0] name, input flavorMask_t exp,
                              input flavorMask_t act);
        if (act !== exp) begin
            $display("FAIL %0s HitOr: expected %b, actual %b", name, exp, act);
            valueErrors++;
        end
    endtask

    task automatic checkDac(input logic [127:0] name, input dacLevel_t expLevel,
                            input logic expValid, input dacLevel_t actLevel,
                            input logic actValid);
        if (actLevel !== expLevel || actValid !== expValid) begin
            $display("FAIL %0s Dac: expected %0d/%b, actual %0d/%b",
                     name, expLevel, expValid, actLevel, actValid);
            valueErrors++;
        end
    endtask

    task automatic checkSo(input logic [127:0] name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %0s SoConf: expected %b, actual %b", name, exp, act);
            valueErrors++;
        end
    endtask

    task automatic checkPending();
        if (pendIdx >= 0) begin
            if (maskV[pendIdx][0])
                checkInj(stepName[pendIdx], expInjV[pendIdx], InjCol);
            if (maskV[pendIdx][1])
                checkMon(stepName[pendIdx], expMonV[pendIdx], {InjMonL, InjMonR});
            if (maskV[pendIdx][2])
                checkHitOr(stepName[pendIdx], expHitV[pendIdx], HitOr);
            if (maskV[pendIdx][3])
                checkDac(stepName[pendIdx], expDacV[pendIdx], expValV[pendIdx],
                         DacLevel, DacValid);
        end
        pendIdx = -1;
    endtask

    task automatic driveInputs(input logic pulse, input logic rstBcid, input digMon_t dig,
                               input logic shift, input logic si, input logic ld,
                               input logic def);
        Pulse     <= pulse;
        ResetBcid <= rstBcid;
        DigMon    <= dig;
        ShiftEn   <= shift;
        SiConf    <= si;
        LdConf    <= ld;
        DefConf   <= def;
    endtask

    task automatic loadTrace();
        int                fd;
        int                fields;
        logic [8*256-1:0]  lineBuf;
        fd = $fopen("testbench/monopix_trace.txt", "r");
        if (fd == 0) begin
            $display("ERROR: cannot open the trace file");
            otherErrors++;
        end else begin
            while ($fgets(lineBuf, fd) != 0) begin
                fields = $sscanf(lineBuf, "%s %s %h %h %h %h %h %h %h %h %h %h %h",
                    stepName[numSteps], stepOp[numSteps], pulseV[numSteps],
                    rstBcidV[numSteps], digMonV[numSteps], wordV[numSteps],
                    maskV[numSteps], expInjV[numSteps], expMonV[numSteps],
                    expHitV[numSteps], expDacV[numSteps], expValV[numSteps],
                    expSoV[numSteps]);
                if (fields == 13 && numSteps < MaxSteps) begin
                    if (stepOp[numSteps] == "s")
                        totalCycles += ConfBits;
                    else if (stepOp[numSteps] == "b")
                        totalCycles += int'(wordV[numSteps][15:0]);
                    else
                        totalCycles += 1;
                    numSteps++;
                end else if (fields > 2) begin
                    $display("ERROR: trace line %0d could not be read", numSteps);
                    otherErrors++;
                end
            end
            $fclose(fd);
            if (numSteps == 0) begin
                $display("ERROR: the trace file holds no steps");
                otherErrors++;
            end
        end
    endtask

    task automatic runStep(input int i);
        int j;
        if (stepOp[i] == "s") begin
            for (j = 0; j < ConfBits; j++) begin   // MSB of the word goes in first
                @(posedge ClkBx);
                driveInputs(pulseV[i], rstBcidV[i], digMonV[i], 1'b1,
                            wordV[i][ConfBits-1-j], 1'b0, 1'b0);
                @(negedge ClkBx);
                checkPending();
                if (maskV[i][4])
                    checkSo(stepName[i], expSoV[i][ConfBits-1-j], SoConf);
            end
        end else if (stepOp[i] == "b") begin
            for (j = 0; j < int'(wordV[i][15:0]); j++) begin
                @(posedge ClkBx);
                driveInputs(pulseV[i], rstBcidV[i], digMonV[i], 1'b0, 1'b0, 1'b0, 1'b0);
                @(negedge ClkBx);
                checkPending();
                checkBcid(stepName[i], grayOf(j), Bcid);   // j edges since the clear
            end
        end else begin
            @(posedge ClkBx);
            driveInputs(pulseV[i], rstBcidV[i], digMonV[i], 1'b0, 1'b0,
                        stepOp[i] == "l", stepOp[i] == "d");
            @(negedge ClkBx);
            checkPending();
            pendIdx = i;
        end
    endtask

    initial begin
        reset_ff  = 1'b1;
        ShiftEn   = 1'b0;
        SiConf    = 1'b0;
        LdConf    = 1'b0;
        DefConf   = 1'b0;
        ResetBcid = 1'b0;
        Pulse     = 1'b1;    // Must not leak through the default config
        DigMon    = '1;
        loadTrace();
        cycleLimit = 2 * (totalCycles + ResetCycles) + 100;
        repeat (ResetCycles) @(posedge ClkBx);
        reset_ff <= 1'b0;
        for (int i = 0; i < numSteps; i++)
            runStep(i);
        @(posedge ClkBx);   // Flush the last registered results
        driveInputs(1'b0, 1'b0, '0, 1'b0, 1'b0, 1'b0, 1'b0);
        @(negedge ClkBx);
        checkPending();
        $display("Errors: %0d wrong values, %0d other", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* testbench/monopix_trace.txt */
# name op pulse rstBcid digMon word mask expInj expMon expHitOr expDac expValid expSo
# mask selects InjCol 01, monitors 02, HitOr 04, DAC 08, SoConf 10 (hex)
defReset  c 1 0 ffffffff 0000000000 0f 00 0 0 09 1 0000000000
defHold   c 1 0 ffffffff 0000000000 0f 00 0 0 09 1 0000000000
shiftW1   s 0 0 00000000 287d2c0010 10 00 0 0 00 0 0000000200
loadW1    l 0 0 00000000 0000000000 00 00 0 0 00 0 0000000000
pulseW1   c 1 0 00000000 0000000000 0b a5 2 0 04 1 0000000000
pulseOff  c 0 0 00000000 0000000000 03 00 0 0 00 0 0000000000
hitCol0   c 0 0 00000001 0000000000 04 00 0 1 00 0 0000000000
hitUnsel  c 0 0 00000010 0000000000 04 00 0 0 00 0 0000000000
hitOffFl  c 0 0 00000200 0000000000 04 00 0 0 00 0 0000000000
hitMixed  c 0 0 08030000 0000000000 04 00 0 4 00 0 0000000000
hitAll    c 0 0 ffffffff 0000000000 04 00 0 5 00 0 0000000000
shiftW2   s 0 0 00000000 287d2d07e0 10 00 0 0 00 0 287d2c0010
loadW2    l 0 0 00000000 0000000000 00 00 0 0 00 0 0000000000
thermo6   c 0 0 00000000 0000000000 08 00 0 0 06 1 0000000000
shiftW3   s 0 0 00000000 287d2c0090 10 00 0 0 00 0 287d2d07e0
loadW3    l 0 0 00000000 0000000000 00 00 0 0 00 0 0000000000
hotTwo    c 0 0 00000000 0000000000 08 00 0 0 00 0 0000000000
shiftW4   s 0 0 00000000 287d2d06e0 10 00 0 0 00 0 287d2c0090
loadW4    l 0 0 00000000 0000000000 00 00 0 0 00 0 0000000000
brokenRun c 0 0 00000000 0000000000 08 00 0 0 00 0 0000000000
bcidClr   c 0 1 00000000 0000000000 00 00 0 0 00 0 0000000000
bcidRun   b 0 0 00000000 0000000046 00 00 0 0 00 0 0000000000
defLoad   d 0 0 00000000 0000000000 00 00 0 0 00 0 0000000000
defCheck  c 1 0 ffffffff 0000000000 0f 00 0 0 09 1 0000000000
shiftDef  s 0 0 00000000 0000000000 10 00 0 0 00 0 0000000200
quiet     c 0 0 00000000 0000000000 0f 00 0 0 09 1 0000000000
